// ==== sim.f ====
src/idct_pkg.sv
src/sram_bus_if.sv
src/dp_ram.sv
src/sram_arbiter.sv
src/block_fetch.sv
src/idct_compute.sv
src/block_writeback.sv
src/idct_top.sv
test/sram_model.sv
test/idct_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the idct testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
	--top-module idct_tb --Mdir "$OBJ" -o idct_sim -f sim.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$OBJ/idct_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Some tests failed" "$LOG"; then
	exit 1
fi
exit 0

// ==== test/idct_tb.sv ====
module idct_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import idct_pkg::*;

	localparam int IMG_STRIDE = 320;
	localparam int PIX_STRIDE = 160;
	localparam int PRE_BASE = 76800;
	localparam int PIX_BASE = 0;
	localparam int MEM_WORDS = 1 << SRAM_AW;
	localparam int NUM_TESTS = 6;
	localparam int MAX_CYCLES = NUM_TESTS * 800 + 100;

	typedef enum {PAT_DC, PAT_AC, PAT_ZERO, PAT_SAT, PAT_RAND} pattern_e;
	typedef enum {EFF_MODEL, EFF_FLAT, EFF_CLIP} effect_e;

	typedef struct {
		int       col;
		int       row;
		pattern_e kind;
		effect_e  effect;
		bit       restart;
	} test_entry_t;

	// block column, block row, pattern, expected effect, second start while busy
	test_entry_t tests [NUM_TESTS] = '{
		'{0, 0, PAT_DC, EFF_FLAT, 1'b0},
		'{5, 3, PAT_AC, EFF_MODEL, 1'b0},
		'{39, 29, PAT_ZERO, EFF_FLAT, 1'b0},
		'{12, 7, PAT_SAT, EFF_CLIP, 1'b0},
		'{1, 0, PAT_RAND, EFF_MODEL, 1'b1},
		'{20, 14, PAT_RAND, EFF_MODEL, 1'b0}
	};

	logic               Clock = 1'b0;
	logic               Resetn;
	logic               start;
	logic [5:0]         block_col;
	logic [4:0]         block_row;
	logic               busy;
	logic               done;
	logic [SRAM_AW-1:0] sram_addr;
	logic [SRAM_DW-1:0] sram_rdata;
	logic [SRAM_DW-1:0] sram_wdata;
	logic               sram_we_n;

	int                 seed = 88;
	int                 errors = 0;
	int                 tests_failed = 0;
	int                 cycles = 0;
	int                 done_cnt = 0;
	int                 write_cnt = 0;
	int                 coef [64];
	int                 ref_pix [64];
	logic [SRAM_DW-1:0] exp_mem [MEM_WORDS];

	idct_top #(
		.IMG_STRIDE(IMG_STRIDE), .PIX_STRIDE(PIX_STRIDE),
		.PRE_BASE(PRE_BASE), .PIX_BASE(PIX_BASE)
	) i_dut (
		.Clock(Clock), .Resetn(Resetn), .start_i(start),
		.block_col_i(block_col), .block_row_i(block_row),
		.busy_o(busy), .done_o(done),
		.sram_address_o(sram_addr), .sram_read_data_i(sram_rdata),
		.sram_write_data_o(sram_wdata), .sram_we_n_o(sram_we_n)
	);

	sram_model i_sram (
		.Clock(Clock), .address_i(sram_addr), .write_data_i(sram_wdata),
		.we_n_i(sram_we_n), .read_data_o(sram_rdata)
	);

	always #2 Clock = ~Clock;

	always @(posedge Clock) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: no done_o after %0d cycles", cycles);
			$display("Some tests failed");
			$finish;
		end
	end

	// outputs are settled by the falling edge
	always @(negedge Clock) begin
		if (Resetn && done)
			done_cnt++;
		if (Resetn && !sram_we_n)
			write_cnt++;
	end

	task automatic report_mismatch(input string name, input int expected, input int actual);
		$display("ERROR t=%0t %s: expected %0d, got %0d", $time, name, expected, actual);
		errors++;
	endtask

	// every address bit reaches the word
	function automatic logic [SRAM_DW-1:0] fill_word(input logic [SRAM_AW-1:0] a);
		return 16'(a ^ (a >> 2)) ^ 16'h5a3c;
	endfunction

	task automatic make_coeffs(input pattern_e kind);
		for (int i = 0; i < 64; i++)
			coef[i] = 0;
		case (kind)
			PAT_DC: coef[0] = 1024;
			PAT_AC: coef[2 * 8 + 3] = 300;
			PAT_SAT: begin
				coef[0] = 4000;
				coef[1] = 3000;
			end
			PAT_RAND: begin
				for (int i = 0; i < 64; i++)
					coef[i] = $random(seed) % 160;
				coef[0] += 1024;
			end
			default: ;
		endcase
	endtask

	// T = S' * C, then S = C^T * T, clipped to a byte
	task automatic model_block();
		longint sum;
		longint v;
		int     t [64];
		for (int r = 0; r < 8; r++) begin
			for (int c = 0; c < 8; c++) begin
				sum = 0;
				for (int k = 0; k < 8; k++)
					sum += longint'(coef[r * 8 + k]) * longint'(c_table[k * 8 + c]);
				t[r * 8 + c] = int'(sum >>> PASS1_SHIFT);
			end
		end
		for (int r = 0; r < 8; r++) begin
			for (int c = 0; c < 8; c++) begin
				sum = 0;
				for (int k = 0; k < 8; k++)
					sum += longint'(c_table[k * 8 + r]) * longint'(t[k * 8 + c]);
				v = sum >>> PASS2_SHIFT;
				ref_pix[r * 8 + c] = (v < 0) ? 0 : ((v > 255) ? 255 : int'(v));
			end
		end
	endtask

	task automatic load_block(input int col, input int row);
		int         cbase;
		int         pbase;
		int         addr;
		sram_word_u w;
		cbase = PRE_BASE + 8 * IMG_STRIDE * row + 8 * col;
		pbase = PIX_BASE + 8 * PIX_STRIDE * row + 4 * col;
		for (int a = 0; a < MEM_WORDS; a++) begin
			exp_mem[a] = fill_word(SRAM_AW'(a));
			i_sram.poke(SRAM_AW'(a), exp_mem[a]);
		end
		for (int i = 0; i < 64; i++) begin
			addr = cbase + (i / 8) * IMG_STRIDE + i % 8;
			w.coeff = 16'(coef[i]);
			exp_mem[addr] = w;
			i_sram.poke(SRAM_AW'(addr), w);
		end
		// even pixel in the high byte
		for (int i = 0; i < 32; i++) begin
			w.pix.hi = 8'(ref_pix[2 * i]);
			w.pix.lo = 8'(ref_pix[2 * i + 1]);
			exp_mem[pbase + (i / 4) * PIX_STRIDE + i % 4] = w;
		end
	endtask

	task automatic check_memory();
		logic [SRAM_DW-1:0] got;
		for (int a = 0; a < MEM_WORDS; a++) begin
			got = i_sram.peek(SRAM_AW'(a));
			assert (got === exp_mem[a])
			else report_mismatch($sformatf("sram[%0d]", a), int'(exp_mem[a]), int'(got));
		end
	endtask

	task automatic check_effect(input int col, input int row, input effect_e effect);
		int         pbase;
		int         n_lo;
		int         n_hi;
		int         pix [64];
		sram_word_u w;
		pbase = PIX_BASE + 8 * PIX_STRIDE * row + 4 * col;
		n_lo = 0;
		n_hi = 0;
		for (int i = 0; i < 32; i++) begin
			w = i_sram.peek(SRAM_AW'(pbase + (i / 4) * PIX_STRIDE + i % 4));
			pix[2 * i] = int'(w.pix.hi);
			pix[2 * i + 1] = int'(w.pix.lo);
		end
		for (int i = 0; i < 64; i++) begin
			if (pix[i] == 0)
				n_lo++;
			if (pix[i] == 255)
				n_hi++;
			if (effect == EFF_FLAT)
				assert (pix[i] == ref_pix[0])
				else report_mismatch($sformatf("pixel %0d", i), ref_pix[0], pix[i]);
		end
		if (effect == EFF_CLIP)
			assert (n_lo > 0 && n_hi > 0)
			else begin
				$display("clip limits not reached: %0d pixels at 0, %0d at 255", n_lo, n_hi);
				errors++;
			end
	endtask

	task automatic run_test(input int idx);
		test_entry_t entry;
		pattern_e    kind;
		int          errs_at_start;
		int          done_at_start;
		int          writes_at_start;
		entry = tests[idx];
		kind = entry.kind;
		errs_at_start = errors;
		make_coeffs(kind);
		model_block();
		load_block(entry.col, entry.row);
		done_at_start = done_cnt;
		writes_at_start = write_cnt;
		@(posedge Clock);
		block_col <= 6'(entry.col);
		block_row <= 5'(entry.row);
		start <= 1'b1;
		@(posedge Clock);
		start <= 1'b0;
		if (entry.restart) begin
			// lands in the compute phase and names another block
			repeat (100) @(posedge Clock);
			@(negedge Clock);
			assert (busy === 1'b1) else report_mismatch("busy_o", 1, int'(busy));
			@(posedge Clock);
			block_col <= 6'(entry.col + 1);
			block_row <= 5'(entry.row + 1);
			start <= 1'b1;
			@(posedge Clock);
			start <= 1'b0;
		end
		while (done_cnt == done_at_start)
			@(negedge Clock);
		repeat (8) @(negedge Clock);
		assert (busy === 1'b0) else report_mismatch("busy_o", 0, int'(busy));
		assert (done_cnt - done_at_start == 1)
		else report_mismatch("done_o pulses", 1, done_cnt - done_at_start);
		assert (write_cnt - writes_at_start == 32)
		else report_mismatch("sram_we_n_o writes", 32, write_cnt - writes_at_start);
		check_memory();
		check_effect(entry.col, entry.row, entry.effect);
		if (errors == errs_at_start) begin
			$display("test %0d %s block (%0d,%0d): pass", idx, kind.name(), entry.col, entry.row);
		end else begin
			$display("test %0d %s block (%0d,%0d): FAIL, %0d errors", idx, kind.name(),
				entry.col, entry.row, errors - errs_at_start);
			tests_failed++;
		end
	endtask

	initial begin
		Resetn = 1'b0;
		start = 1'b0;
		block_col = '0;
		block_row = '0;
		repeat (8) @(posedge Clock);
		Resetn <= 1'b1;
		@(negedge Clock);
		assert (sram_we_n === 1'b1) else report_mismatch("sram_we_n_o", 1, int'(sram_we_n));
		assert (busy === 1'b0) else report_mismatch("busy_o", 0, int'(busy));
		assert (done === 1'b0) else report_mismatch("done_o", 0, int'(done));
		$display("reset state: %s", (errors == 0) ? "pass" : "FAIL");
		for (int i = 0; i < NUM_TESTS; i++)
			run_test(i);
		$display("%0d of %0d tests passed, %0d errors", NUM_TESTS - tests_failed, NUM_TESTS,
			errors);
		if (errors == 0 && tests_failed == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

// ==== test/sram_model.sv ====
module sram_model (
	input  logic                         Clock,
	input  logic [idct_pkg::SRAM_AW-1:0] address_i,
	input  logic [idct_pkg::SRAM_DW-1:0] write_data_i,
	input  logic                         we_n_i,
	output logic [idct_pkg::SRAM_DW-1:0] read_data_o
);
	timeunit 1ns;
	timeprecision 100ps;
	import idct_pkg::*;

	logic [SRAM_DW-1:0] mem [1 << SRAM_AW];
	logic [SRAM_DW-1:0] rd_q;

	// read data shows up two edges after its address
	always @(posedge Clock) begin
		if (!we_n_i)
			mem[address_i] = write_data_i;
		rd_q <= mem[address_i];
		read_data_o <= rd_q;
	end

	// backdoor access for the testbench
	task automatic poke(input logic [SRAM_AW-1:0] addr, input logic [SRAM_DW-1:0] data);
		mem[addr] = data;
	endtask

	function automatic logic [SRAM_DW-1:0] peek(input logic [SRAM_AW-1:0] addr);
		return mem[addr];
	endfunction

endmodule

// ==== src/idct_top.sv ====
module idct_top #(
	parameter int IMG_STRIDE = 320,
	parameter int PIX_STRIDE = 160,
	parameter int PRE_BASE = 76800,
	parameter int PIX_BASE = 0
) (
	input  logic                         Clock,
	input  logic                         Resetn,
	input  logic                         start_i,
	input  logic [5:0]                   block_col_i,
	input  logic [4:0]                   block_row_i,
	output logic                         busy_o,
	output logic                         done_o,
	output logic [idct_pkg::SRAM_AW-1:0] sram_address_o,
	input  logic [idct_pkg::SRAM_DW-1:0] sram_read_data_i,
	output logic [idct_pkg::SRAM_DW-1:0] sram_write_data_o,
	output logic                         sram_we_n_o
);
	import idct_pkg::*;

	logic              fetch_start;
	logic              fetch_busy;
	logic              fetch_done;
	logic              calc_busy;
	logic              calc_done;
	logic              wb_busy;
	logic [5:0]        blk_col;
	logic [4:0]        blk_row;
	logic [RAM_AW-1:0] f_addr;
	logic [31:0]       f_wdata;
	logic              f_we;
	logic [RAM_AW-1:0] c0_addr_a;
	logic [RAM_AW-1:0] c0_addr_b;
	logic [31:0]       c0_wdata;
	logic              c0_we;
	logic [RAM_AW-1:0] c1_addr_a;
	logic [RAM_AW-1:0] c1_addr_b;
	logic [31:0]       c1_wdata;
	logic              c1_we;
	logic [RAM_AW-1:0] w_addr_a;
	logic [RAM_AW-1:0] w_addr_b;
	logic [RAM_AW-1:0] r0_addr_a;
	logic [RAM_AW-1:0] r0_addr_b;
	logic [31:0]       r0_wdata;
	logic              r0_we;
	logic [31:0]       r0_rdata_a;
	logic [31:0]       r0_rdata_b;
	logic [31:0]       r1_rdata_a;
	logic [31:0]       r1_rdata_b;

	sram_bus_if fetch_bus ();
	sram_bus_if calc_bus ();
	sram_bus_if wb_bus ();

	assign busy_o = fetch_busy | calc_busy | wb_busy;
	assign fetch_start = start_i & ~busy_o;

	// phases never overlap, so busy picks the RAM0 owner
	always_comb begin
		r0_addr_b = calc_busy ? c0_addr_b : w_addr_b;
		if (calc_busy) begin
			r0_addr_a = c0_addr_a;
			r0_wdata = c0_wdata;
			r0_we = c0_we;
		end else if (wb_busy) begin
			r0_addr_a = w_addr_a;
			r0_wdata = '0;
			r0_we = 1'b0;
		end else begin
			r0_addr_a = f_addr;
			r0_wdata = f_wdata;
			r0_we = f_we;
		end
	end

	sram_arbiter i_arb (
		.Clock(Clock), .Resetn(Resetn),
		.fetch_bus(fetch_bus), .calc_bus(calc_bus), .wb_bus(wb_bus),
		.sram_address_o(sram_address_o), .sram_read_data_i(sram_read_data_i),
		.sram_write_data_o(sram_write_data_o), .sram_we_n_o(sram_we_n_o)
	);

	dp_ram #(.DEPTH(1 << RAM_AW)) i_ram0 (
		.Clock(Clock), .addr_a_i(r0_addr_a), .addr_b_i(r0_addr_b),
		.wdata_a_i(r0_wdata), .wdata_b_i(32'd0), .we_a_i(r0_we), .we_b_i(1'b0),
		.rdata_a_o(r0_rdata_a), .rdata_b_o(r0_rdata_b)
	);

	dp_ram #(.DEPTH(1 << RAM_AW)) i_ram1 (
		.Clock(Clock), .addr_a_i(c1_addr_a), .addr_b_i(c1_addr_b),
		.wdata_a_i(c1_wdata), .wdata_b_i(32'd0), .we_a_i(c1_we), .we_b_i(1'b0),
		.rdata_a_o(r1_rdata_a), .rdata_b_o(r1_rdata_b)
	);

	block_fetch #(.IMG_STRIDE(IMG_STRIDE), .PRE_BASE(PRE_BASE)) i_fetch (
		.Clock(Clock), .Resetn(Resetn), .start_i(fetch_start),
		.block_col_i(block_col_i), .block_row_i(block_row_i), .bus(fetch_bus),
		.ram_addr_o(f_addr), .ram_wdata_o(f_wdata), .ram_we_o(f_we),
		.blk_col_o(blk_col), .blk_row_o(blk_row),
		.busy_o(fetch_busy), .done_o(fetch_done)
	);

	idct_compute i_calc (
		.Clock(Clock), .Resetn(Resetn), .start_i(fetch_done),
		.ram0_addr_a_o(c0_addr_a), .ram0_addr_b_o(c0_addr_b),
		.ram0_rdata_a_i(r0_rdata_a), .ram0_rdata_b_i(r0_rdata_b),
		.ram0_wdata_o(c0_wdata), .ram0_we_o(c0_we),
		.ram1_addr_a_o(c1_addr_a), .ram1_addr_b_o(c1_addr_b),
		.ram1_rdata_a_i(r1_rdata_a), .ram1_rdata_b_i(r1_rdata_b),
		.ram1_wdata_o(c1_wdata), .ram1_we_o(c1_we),
		.bus(calc_bus), .busy_o(calc_busy), .done_o(calc_done)
	);

	block_writeback #(.PIX_STRIDE(PIX_STRIDE), .PIX_BASE(PIX_BASE)) i_wb (
		.Clock(Clock), .Resetn(Resetn), .start_i(calc_done),
		.blk_col_i(blk_col), .blk_row_i(blk_row),
		.ram_addr_a_o(w_addr_a), .ram_addr_b_o(w_addr_b),
		.ram_rdata_a_i(r0_rdata_a), .ram_rdata_b_i(r0_rdata_b),
		.bus(wb_bus), .busy_o(wb_busy), .done_o(done_o)
	);

endmodule

// ==== src/block_writeback.sv ====
module block_writeback #(
	parameter int PIX_STRIDE = 160,
	parameter int PIX_BASE = 0
) (
	input  logic                        Clock,
	input  logic                        Resetn,
	input  logic                        start_i,
	input  logic [5:0]                  blk_col_i,
	input  logic [4:0]                  blk_row_i,
	output logic [idct_pkg::RAM_AW-1:0] ram_addr_a_o,
	output logic [idct_pkg::RAM_AW-1:0] ram_addr_b_o,
	input  logic [31:0]                 ram_rdata_a_i,
	input  logic [31:0]                 ram_rdata_b_i,
	sram_bus_if.client                  bus,
	output logic                        busy_o,
	output logic                        done_o
);
	import idct_pkg::*;

	wb_state_e          state;
	logic [4:0]         w;
	logic [4:0]         w_nxt;
	logic [SRAM_AW-1:0] base_q;
	logic [SRAM_AW-1:0] row_off;
	sram_word_u         word;

	always_ff @(posedge Clock) begin
		if (state == WB_IDLE && start_i)
			base_q <= SRAM_AW'(PIX_BASE + 8 * PIX_STRIDE * blk_row_i + 4 * blk_col_i);
	end

	always_ff @(posedge Clock or negedge Resetn) begin
		if (!Resetn) begin
			state <= WB_IDLE;
			w <= '0;
			row_off <= '0;
			done_o <= 1'b0;
		end else begin
			done_o <= 1'b0;
			case (state)
				WB_IDLE: begin
					if (start_i) begin
						state <= WB_WRITE;
						row_off <= '0;
					end
				end
				WB_WRITE: begin
					if (bus.gnt) begin
						w <= w + 5'd1;
						if (w[1:0] == 2'd3)
							row_off <= row_off + SRAM_AW'(PIX_STRIDE);
						if (w == 5'd31) begin
							state <= WB_IDLE;
							done_o <= 1'b1;
						end
					end
				end
				default: state <= WB_IDLE;
			endcase
		end
	end

	// look one word ahead so RAM data is ready on each grant
	assign w_nxt = (state == WB_WRITE && bus.gnt) ? w + 5'd1 : w;
	assign ram_addr_a_o = {w_nxt, 1'b0};
	assign ram_addr_b_o = {w_nxt, 1'b1};

	// even pixel goes in the high byte
	assign word.pix.hi = ram_rdata_a_i[7:0];
	assign word.pix.lo = ram_rdata_b_i[7:0];

	assign bus.req = (state == WB_WRITE);
	assign bus.we_n = (state != WB_WRITE);
	assign bus.addr = base_q + row_off + SRAM_AW'(w[1:0]);
	assign bus.wdata = word;

	assign busy_o = (state != WB_IDLE);

endmodule

// ==== src/idct_compute.sv ====
module idct_compute (
	input  logic                        Clock,
	input  logic                        Resetn,
	input  logic                        start_i,
	output logic [idct_pkg::RAM_AW-1:0] ram0_addr_a_o,
	output logic [idct_pkg::RAM_AW-1:0] ram0_addr_b_o,
	input  logic [31:0]                 ram0_rdata_a_i,
	input  logic [31:0]                 ram0_rdata_b_i,
	output logic [31:0]                 ram0_wdata_o,
	output logic                        ram0_we_o,
	output logic [idct_pkg::RAM_AW-1:0] ram1_addr_a_o,
	output logic [idct_pkg::RAM_AW-1:0] ram1_addr_b_o,
	input  logic [31:0]                 ram1_rdata_a_i,
	input  logic [31:0]                 ram1_rdata_b_i,
	output logic [31:0]                 ram1_wdata_o,
	output logic                        ram1_we_o,
	sram_bus_if.client                  bus,
	output logic                        busy_o,
	output logic                        done_o
);
	import idct_pkg::*;

	calc_state_e        state;
	logic [8:0]         cnt;
	logic [7:0]         rd_idx;
	logic [7:0]         pr_idx;
	logic [RAM_AW-1:0]  rd_a;
	logic [RAM_AW-1:0]  rd_b;
	logic [2:0]         tap_j;
	logic signed [31:0] op_a;
	logic signed [31:0] op_b;
	logic signed [15:0] coef_a;
	logic signed [15:0] coef_b;
	logic signed [47:0] prod_sum;
	logic signed [47:0] acc;
	logic signed [47:0] total;
	logic signed [47:0] scaled;
	logic               proc_vld;
	logic               wr_en;
	logic [7:0]         pix;

	// index = {element, pair}, issued one cycle ahead of its use
	assign rd_idx = cnt[7:0] - 8'd1;
	assign pr_idx = cnt[7:0] - 8'd2;

	always_comb begin
		if (state == CALC_PASS2) begin
			// column of T against column r of C
			rd_a = {rd_idx[1:0], 1'b0, rd_idx[4:2]};
			rd_b = {rd_idx[1:0], 1'b1, rd_idx[4:2]};
			tap_j = pr_idx[7:5];
			op_a = ram1_rdata_a_i;
			op_b = ram1_rdata_b_i;
		end else begin
			// row of S' against column c of C
			rd_a = {rd_idx[7:5], rd_idx[1:0], 1'b0};
			rd_b = {rd_idx[7:5], rd_idx[1:0], 1'b1};
			tap_j = pr_idx[4:2];
			op_a = ram0_rdata_a_i;
			op_b = ram0_rdata_b_i;
		end
	end

	assign coef_a = c_table[{pr_idx[1:0], 1'b0, tap_j}];
	assign coef_b = c_table[{pr_idx[1:0], 1'b1, tap_j}];
	assign prod_sum = op_a * coef_a + op_b * coef_b;

	assign proc_vld = (state != CALC_IDLE) && (cnt >= 9'd2);
	assign wr_en = proc_vld && (pr_idx[1:0] == 2'd3);
	assign total = acc + prod_sum;
	assign scaled = total >>> ((state == CALC_PASS2) ? PASS2_SHIFT : PASS1_SHIFT);

	always_comb begin
		if (scaled < 0)
			pix = 8'd0;
		else if (scaled > 48'sd255)
			pix = 8'd255;
		else
			pix = scaled[7:0];
	end

	always_ff @(posedge Clock) begin
		if (proc_vld)
			acc <= (pr_idx[1:0] == 2'd0) ? prod_sum : total;
	end

	always_ff @(posedge Clock or negedge Resetn) begin
		if (!Resetn) begin
			state <= CALC_IDLE;
			cnt <= '0;
		end else begin
			case (state)
				CALC_IDLE: begin
					if (start_i)
						state <= CALC_PASS1;
				end
				CALC_PASS1: begin
					cnt <= (cnt == 9'd257) ? 9'd0 : cnt + 9'd1;
					if (cnt == 9'd257)
						state <= CALC_PASS2;
				end
				CALC_PASS2: begin
					cnt <= (cnt == 9'd257) ? 9'd0 : cnt + 9'd1;
					if (cnt == 9'd257)
						state <= CALC_IDLE;
				end
				default: state <= CALC_IDLE;
			endcase
		end
	end

	// pass 1 fills T in RAM1, pass 2 puts S back in RAM0
	assign ram0_addr_a_o = (state == CALC_PASS2) ? pr_idx[7:2] : rd_a;
	assign ram0_addr_b_o = rd_b;
	assign ram0_wdata_o = {24'd0, pix};
	assign ram0_we_o = wr_en && (state == CALC_PASS2);
	assign ram1_addr_a_o = (state == CALC_PASS2) ? rd_a : pr_idx[7:2];
	assign ram1_addr_b_o = rd_b;
	assign ram1_wdata_o = scaled[31:0];
	assign ram1_we_o = wr_en && (state == CALC_PASS1);

	// no SRAM traffic from this stage
	assign bus.req = 1'b0;
	assign bus.addr = '0;
	assign bus.wdata = '0;
	assign bus.we_n = 1'b1;

	assign busy_o = (state != CALC_IDLE);
	assign done_o = (state == CALC_PASS2) && (cnt == 9'd257);

	a_out_addr: assert property (@(posedge Clock) disable iff (!Resetn)
		wr_en |-> ((cnt - 9'd2) >> 2) < 9'd64)
		else $error("idct_compute: output address out of range");

	a_never_granted: assert property (@(posedge Clock) disable iff (!Resetn) !bus.gnt)
		else $error("idct_compute: granted without a request");

endmodule

// ==== src/block_fetch.sv ====
module block_fetch #(
	parameter int IMG_STRIDE = 320,
	parameter int PRE_BASE = 76800
) (
	input  logic                        Clock,
	input  logic                        Resetn,
	input  logic                        start_i,
	input  logic [5:0]                  block_col_i,
	input  logic [4:0]                  block_row_i,
	sram_bus_if.client                  bus,
	output logic [idct_pkg::RAM_AW-1:0] ram_addr_o,
	output logic [31:0]                 ram_wdata_o,
	output logic                        ram_we_o,
	output logic [5:0]                  blk_col_o,
	output logic [4:0]                  blk_row_o,
	output logic                        busy_o,
	output logic                        done_o
);
	import idct_pkg::*;

	fetch_state_e       state;
	logic [6:0]         cnt;
	logic [SRAM_AW-1:0] base_q;
	logic [SRAM_AW-1:0] row_off;
	sram_word_u         rd_word;

	always_ff @(posedge Clock) begin
		if (state == FETCH_IDLE && start_i) begin
			base_q <= SRAM_AW'(PRE_BASE + 8 * IMG_STRIDE * block_row_i + 8 * block_col_i);
			blk_col_o <= block_col_i;
			blk_row_o <= block_row_i;
		end
	end

	// cnt only moves once granted, so read 0 waits on the address
	always_ff @(posedge Clock or negedge Resetn) begin
		if (!Resetn) begin
			state <= FETCH_IDLE;
			cnt <= '0;
			row_off <= '0;
		end else begin
			case (state)
				FETCH_IDLE: begin
					if (start_i) begin
						state <= FETCH_RUN;
						row_off <= '0;
					end
				end
				FETCH_RUN: begin
					if (bus.gnt) begin
						cnt <= cnt + 7'd1;
						if (cnt < 7'd64 && cnt[2:0] == 3'd7)
							row_off <= row_off + SRAM_AW'(IMG_STRIDE);
						if (cnt == 7'd66) begin
							state <= FETCH_IDLE;
							cnt <= '0;
						end
					end
				end
				default: state <= FETCH_IDLE;
			endcase
		end
	end

	assign bus.req = (state == FETCH_RUN);
	assign bus.addr = base_q + row_off + SRAM_AW'(cnt[2:0]);
	assign bus.wdata = '0;
	assign bus.we_n = 1'b1;

	// data lands two cycles behind its address
	assign rd_word = bus.rdata;
	assign ram_wdata_o = {{16{rd_word.coeff[15]}}, rd_word.coeff};
	assign ram_addr_o = cnt[5:0] - 6'd2;
	assign ram_we_o = (state == FETCH_RUN) && (cnt >= 7'd2) && (cnt <= 7'd65);

	assign busy_o = (state != FETCH_IDLE);
	assign done_o = (state == FETCH_RUN) && (cnt == 7'd66);

endmodule

// ==== src/sram_arbiter.sv ====
module sram_arbiter (
	input  logic                         Clock,
	input  logic                         Resetn,
	sram_bus_if.arb                      fetch_bus,
	sram_bus_if.arb                      calc_bus,
	sram_bus_if.arb                      wb_bus,
	output logic [idct_pkg::SRAM_AW-1:0] sram_address_o,
	input  logic [idct_pkg::SRAM_DW-1:0] sram_read_data_i,
	output logic [idct_pkg::SRAM_DW-1:0] sram_write_data_o,
	output logic                         sram_we_n_o
);

	// one-hot owner, bit 0 is fetch
	logic [2:0] gnt_q;
	logic [2:0] req_vec;

	assign req_vec = {wb_bus.req, calc_bus.req, fetch_bus.req};

	always_ff @(posedge Clock or negedge Resetn) begin
		if (!Resetn) begin
			gnt_q <= 3'b000;
		end else if (gnt_q == 3'b000) begin
			if (fetch_bus.req)
				gnt_q <= 3'b001;
			else if (calc_bus.req)
				gnt_q <= 3'b010;
			else if (wb_bus.req)
				gnt_q <= 3'b100;
		end else if ((gnt_q & req_vec) == 3'b000) begin
			gnt_q <= 3'b000;
		end
	end

	assign fetch_bus.gnt = gnt_q[0];
	assign calc_bus.gnt = gnt_q[1];
	assign wb_bus.gnt = gnt_q[2];

	assign fetch_bus.rdata = sram_read_data_i;
	assign calc_bus.rdata = sram_read_data_i;
	assign wb_bus.rdata = sram_read_data_i;

	// only the owner reaches the pins
	always_comb begin
		sram_address_o = '0;
		sram_write_data_o = '0;
		sram_we_n_o = 1'b1;
		case (gnt_q)
			3'b001: begin
				sram_address_o = fetch_bus.addr;
				sram_write_data_o = fetch_bus.wdata;
				sram_we_n_o = fetch_bus.we_n;
			end
			3'b010: begin
				sram_address_o = calc_bus.addr;
				sram_write_data_o = calc_bus.wdata;
				sram_we_n_o = calc_bus.we_n;
			end
			3'b100: begin
				sram_address_o = wb_bus.addr;
				sram_write_data_o = wb_bus.wdata;
				sram_we_n_o = wb_bus.we_n;
			end
			default: ;
		endcase
	end

	a_one_grant: assert property (@(posedge Clock) disable iff (!Resetn)
		$onehot0({wb_bus.gnt, calc_bus.gnt, fetch_bus.gnt}))
		else $error("sram_arbiter: more than one grant");

endmodule

// ==== src/dp_ram.sv ====
module dp_ram #(
	parameter int DEPTH = 64
) (
	input  logic                     Clock,
	input  logic [$clog2(DEPTH)-1:0] addr_a_i,
	input  logic [$clog2(DEPTH)-1:0] addr_b_i,
	input  logic [31:0]              wdata_a_i,
	input  logic [31:0]              wdata_b_i,
	input  logic                     we_a_i,
	input  logic                     we_b_i,
	output logic [31:0]              rdata_a_o,
	output logic [31:0]              rdata_b_o
);

	logic [31:0] mem [DEPTH];

	always_ff @(posedge Clock) begin
		if (we_a_i)
			mem[addr_a_i] <= wdata_a_i;
		if (we_b_i)
			mem[addr_b_i] <= wdata_b_i;
		rdata_a_o <= mem[addr_a_i];
		rdata_b_o <= mem[addr_b_i];
	end

	a_no_write_clash: assert property (@(posedge Clock)
		!(we_a_i && we_b_i && (addr_a_i == addr_b_i)))
		else $error("dp_ram: both ports write address %0d", addr_a_i);

endmodule

// ==== src/sram_bus_if.sv ====
interface sram_bus_if;
	import idct_pkg::*;

	logic               req;
	logic               gnt;
	logic [SRAM_AW-1:0] addr;
	logic [SRAM_DW-1:0] wdata;
	logic               we_n;
	logic [SRAM_DW-1:0] rdata;

	modport client (
		output req, addr, wdata, we_n,
		input  gnt, rdata
	);

	modport arb (
		input  req, addr, wdata, we_n,
		output gnt, rdata
	);

endinterface

// ==== src/idct_pkg.sv ====
package idct_pkg;

	localparam int SRAM_AW = 18;
	localparam int SRAM_DW = 16;
	localparam int RAM_AW = 6;

	localparam int PASS1_SHIFT = 8;
	localparam int PASS2_SHIFT = 16;

	// basis index picks the row and sample index the column
	localparam logic signed [15:0] c_table [64] = '{
		16'sd1448, 16'sd1448, 16'sd1448, 16'sd1448, 16'sd1448, 16'sd1448, 16'sd1448, 16'sd1448,
		16'sd2008, 16'sd1702, 16'sd1137, 16'sd399, -16'sd399, -16'sd1137, -16'sd1702, -16'sd2008,
		16'sd1892, 16'sd783, -16'sd783, -16'sd1892, -16'sd1892, -16'sd783, 16'sd783, 16'sd1892,
		16'sd1702, -16'sd399, -16'sd2008, -16'sd1137, 16'sd1137, 16'sd2008, 16'sd399, -16'sd1702,
		16'sd1448, -16'sd1448, -16'sd1448, 16'sd1448, 16'sd1448, -16'sd1448, -16'sd1448, 16'sd1448,
		16'sd1137, -16'sd2008, 16'sd399, 16'sd1702, -16'sd1702, -16'sd399, 16'sd2008, -16'sd1137,
		16'sd783, -16'sd1892, 16'sd1892, -16'sd783, -16'sd783, 16'sd1892, -16'sd1892, 16'sd783,
		16'sd399, -16'sd1137, 16'sd1702, -16'sd2008, 16'sd2008, -16'sd1702, 16'sd1137, -16'sd399
	};

	typedef struct packed {
		logic [7:0] hi;
		logic [7:0] lo;
	} pix_pair_t;

	// one sram word seen as a coefficient or as two pixels
	typedef union packed {
		logic signed [15:0] coeff;
		pix_pair_t          pix;
	} sram_word_u;

	typedef enum logic {FETCH_IDLE, FETCH_RUN} fetch_state_e;
	typedef enum logic [1:0] {CALC_IDLE, CALC_PASS1, CALC_PASS2} calc_state_e;
	typedef enum logic {WB_IDLE, WB_WRITE} wb_state_e;

endpackage
